// ==== Bender.yml ====
package:
  name: lsu

sources:
  - memOpPkg.sv
  - lsuBusPkg.sv
  - accessDecode.sv
  - storeAlign.sv
  - loadExtract.sv
  - dataRam.sv
  - lsuTop.sv
  - target: test
    files:
      - tbLsu.sv

// ==== accessDecode.sv ====
// access decode: width, sign, lane offset and doubleword crossing
`default_nettype none

module accessDecode (
    input  memOpPkg::memOpE       op,
    input  logic [63:0]           addr,
    output lsuBusPkg::accessInfoT info
);

    memOpPkg::accessSizeE size;
    logic [2:0]           offset;
    logic                 crosses;
    logic [3:0]           endByte;

    assign size   = memOpPkg::accessSizeE'(op[1:0]);
    assign offset = addr[2:0];

    // crossing table per width
    always_comb begin
        case (size)
            memOpPkg::size1: begin
                crosses = 1'b0;  // a byte always fits
            end
            memOpPkg::size2: begin
                crosses = (offset == 3'd7);
            end
            memOpPkg::size4: begin
                crosses = (offset > 3'd4);
            end
            default: begin
                crosses = (offset != 3'd0);
            end
        endcase
    end

    assign info = '{
        size:       size,
        signedLoad: ~op[2],
        laneOffset: offset,
        misaligned: crosses
    };

    // first byte past the access, 8 means it ends on the boundary
    assign endByte = {1'b0, offset} + memOpPkg::sizeBytes(size);

    // table must agree with offset + bytes > 8
    always_comb begin
        misalignRule: assert #0 (crosses == (endByte > 4'd8))
            else $error("accessDecode: crossing table disagrees for offset %0d", offset);
    end

endmodule

`default_nettype wire

// ==== dataRam.sv ====
// doubleword RAM, byte-masked write, combinational read
`default_nettype none

module dataRam #(
    parameter int memDepth = 64
) (
    input  logic                clk,
    input  lsuBusPkg::ramWriteT ramWr,
    input  logic [63:0]         rdAddr,
    output logic [63:0]         rdWord
);

    localparam int idxW = $clog2(memDepth);

    logic [63:0]     mem [memDepth];
    logic [idxW-1:0] wrIdx;
    logic [idxW-1:0] rdIdx;

    // upper address bits ignored, so accesses wrap
    assign wrIdx = ramWr.wordAddr[idxW-1:0];
    assign rdIdx = rdAddr[idxW+2:3];

    always_ff @(posedge clk) begin
        if (ramWr.we) begin
            for (int i = 0; i < 8; i++) begin
                if (ramWr.mask[i]) begin
                    mem[wrIdx][8*i +: 8] <= ramWr.data[8*i +: 8];
                end
            end
        end
    end

    // read sees old word in the write cycle
    assign rdWord = mem[rdIdx];

endmodule

`default_nettype wire

// ==== filelist.f ====
memOpPkg.sv
lsuBusPkg.sv
accessDecode.sv
storeAlign.sv
loadExtract.sv
dataRam.sv
lsuTop.sv
tbLsu.sv

// ==== loadExtract.sv ====
// load byte select, sign/zero extension and registered response
`default_nettype none

module loadExtract (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  ren,
    input  logic                  wen,
    input  memOpPkg::memOpE       op,
    input  lsuBusPkg::accessInfoT info,
    input  logic [63:0]           rdWord,
    output lsuBusPkg::loadRespT   resp,
    output logic                  storeFault
);

    logic [63:0] shifted;
    logic [63:0] extended;
    logic        fill;
    logic        validQ;
    logic        faultQ;
    logic [63:0] dataQ;

    assign shifted = rdWord >> {info.laneOffset, 3'b000};

    always_comb begin
        case (info.size)
            memOpPkg::size1: begin
                fill     = info.signedLoad & shifted[7];
                extended = {{56{fill}}, shifted[7:0]};
            end
            memOpPkg::size2: begin
                fill     = info.signedLoad & shifted[15];
                extended = {{48{fill}}, shifted[15:0]};
            end
            memOpPkg::size4: begin
                fill     = info.signedLoad & shifted[31];
                extended = {{32{fill}}, shifted[31:0]};
            end
            default: begin
                fill     = 1'b0;
                extended = shifted;
            end
        endcase
        if (&op) begin
            extended = '0;  // code 111 has no load
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ     <= 1'b0;
            faultQ     <= 1'b0;
            storeFault <= 1'b0;
        end else begin
            validQ     <= ren;
            faultQ     <= ren & info.misaligned;
            storeFault <= wen & info.misaligned;
        end
    end

    // payload moves only with a load
    always_ff @(posedge clk) begin
        if (ren) begin
            dataQ <= info.misaligned ? 64'd0 : extended;  // faults return zero
        end
    end

    assign resp = '{valid: validQ, fault: faultQ, data: dataQ};

    // extension width and sign come from info, code 111 from op
    opInfoAgree: assert property (@(posedge clk) disable iff (!rstN)
        ren |-> (info.size == memOpPkg::accessSizeE'(op[1:0]))
                && (info.signedLoad == ~op[2]))
        else $error("loadExtract: decoded access disagrees with the operation code");

endmodule

`default_nettype wire

// ==== lsuBusPkg.sv ====
// structs passed between the load/store blocks
`default_nettype none

package lsuBusPkg;

    // one request per cycle, plain strobes
    typedef struct packed {
        logic            ren;
        logic            wen;
        memOpPkg::memOpE op;
        logic [63:0]     addr;
        logic [63:0]     wdata;
    } memReqT;

    typedef struct packed {
        memOpPkg::accessSizeE size;
        logic                 signedLoad;
        logic [2:0]           laneOffset;
        logic                 misaligned;  // bytes would cross the doubleword
    } accessInfoT;

    typedef struct packed {
        logic        we;
        logic [63:0] wordAddr;  // byte address >> 3
        logic [63:0] data;
        logic [7:0]  mask;
    } ramWriteT;

    typedef struct packed {
        logic        valid;
        logic        fault;
        logic [63:0] data;
    } loadRespT;

endpackage

`default_nettype wire

// ==== lsuTop.sv ====
// load/store unit top: decode, store align, RAM and load extract
`default_nettype none

module lsuTop #(
    parameter int memDepth = 64
) (
    input  logic                clk,
    input  logic                rstN,
    input  lsuBusPkg::memReqT   req,
    output lsuBusPkg::loadRespT resp,
    output logic                storeFault
);

    lsuBusPkg::accessInfoT info;
    lsuBusPkg::ramWriteT   ramWr;
    logic [63:0]           rdWord;

    accessDecode uDecode (
        .op   (req.op),
        .addr (req.addr),
        .info (info)
    );

    storeAlign uStore (
        .req   (req),
        .info  (info),
        .ramWr (ramWr)
    );

    dataRam #(
        .memDepth (memDepth)
    ) uRam (
        .clk    (clk),
        .ramWr  (ramWr),
        .rdAddr (req.addr),
        .rdWord (rdWord)
    );

    // load path and both fault flags
    loadExtract uLoad (
        .clk        (clk),
        .rstN       (rstN),
        .ren        (req.ren),
        .wen        (req.wen),
        .op         (req.op),
        .info       (info),
        .rdWord     (rdWord),
        .resp       (resp),
        .storeFault (storeFault)
    );

endmodule

`default_nettype wire

// ==== memOpPkg.sv ====
// memory operation encodings and access size helpers
`default_nettype none

package memOpPkg;

    // low two bits give the width, bit 2 marks unsigned loads
    typedef enum logic [2:0] {
        opLw  = 3'b000,
        opLb  = 3'b001,
        opLh  = 3'b010,
        opLd  = 3'b011,
        opLwu = 3'b100,
        opLbu = 3'b101,
        opLhu = 3'b110
    } memOpE;

    typedef enum logic [1:0] {
        size4 = 2'b00,
        size1 = 2'b01,
        size2 = 2'b10,
        size8 = 2'b11
    } accessSizeE;

    function automatic logic [3:0] sizeBytes(accessSizeE size);
        case (size)
            size1:   return 4'd1;
            size2:   return 4'd2;
            size4:   return 4'd4;
            default: return 4'd8;
        endcase
    endfunction

    // byte mask of the access before it is moved to its lane
    function automatic logic [7:0] sizeMask(accessSizeE size);
        case (size)
            size1:   return 8'h01;
            size2:   return 8'h03;
            size4:   return 8'h0f;
            default: return 8'hff;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== storeAlign.sv ====
// store lane placement and byte write mask
`default_nettype none

module storeAlign (
    input  lsuBusPkg::memReqT     req,
    input  lsuBusPkg::accessInfoT info,
    output lsuBusPkg::ramWriteT   ramWr
);

    logic [7:0]  lowMask;
    logic [63:0] lowData;
    logic [7:0]  laneMask;
    logic [63:0] laneData;
    logic [5:0]  bitShift;
    logic        writeEn;

    assign lowMask = memOpPkg::sizeMask(info.size);

    // keep only the bytes being stored
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lowData[8*i +: 8] = lowMask[i] ? req.wdata[8*i +: 8] : 8'h00;
        end
    end

    assign bitShift = {info.laneOffset, 3'b000};
    assign laneData = lowData << bitShift;  // other lanes zero-filled
    assign laneMask = lowMask << info.laneOffset;

    // crossing stores are dropped, fault reported by loadExtract
    assign writeEn = req.wen & ~info.misaligned;

    assign ramWr = '{
        we:       writeEn,
        wordAddr: {3'b000, req.addr[63:3]},
        data:     laneData,
        mask:     laneMask
    };

    always_comb begin
        maskNotEmpty: assert #0 (!ramWr.we || ramWr.mask != 8'h00)
            else $error("storeAlign: write enabled with empty byte mask");
    end

endmodule

`default_nettype wire

// ==== tbLsu.sv ====
// load/store unit testbench with a byte-array memory model
`default_nettype none

module tbLsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int memDepth    = 64;
    localparam int modelBytes  = memDepth * 8;
    localparam int respTimeout = 20;

    logic                clk;
    logic                rstN;
    lsuBusPkg::memReqT   req;
    lsuBusPkg::loadRespT resp;
    logic                storeFault;

    logic [7:0]          modelMem [modelBytes];
    lsuBusPkg::loadRespT expQ [$];
    logic [63:0]         addrQ [$];
    logic                expFaultNext;
    integer              seed;
    int                  loadErrors;
    int                  faultErrors;
    int                  otherErrors;

    lsuTop #(
        .memDepth (memDepth)
    ) UUT (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .resp       (resp),
        .storeFault (storeFault)
    );

    always #5 clk = ~clk;

    function automatic int byteCount(logic [2:0] code);
        case (code[1:0])
            2'b00:   return 4;
            2'b01:   return 1;
            2'b10:   return 2;
            default: return 8;
        endcase
    endfunction

    function automatic logic crossesLane(logic [2:0] code, logic [63:0] addr);
        return (int'(addr[2:0]) + byteCount(code)) > 8;
    endfunction

    function automatic logic [63:0] randWord();
        logic [63:0] w;
        w[63:32] = $random(seed);
        w[31:0]  = $random(seed);
        return w;
    endfunction

    // expected response from the model bytes, before this cycle's store
    function automatic lsuBusPkg::loadRespT expectedLoad(logic [2:0] code, logic [63:0] addr);
        lsuBusPkg::loadRespT r;
        logic [63:0]         raw;
        int                  n;
        int                  base;
        n       = byteCount(code);
        base    = int'(addr % modelBytes);
        raw     = '0;
        r.valid = 1'b1;
        r.fault = crossesLane(code, addr);
        r.data  = '0;
        if (!r.fault && code != 3'b111) begin
            for (int i = 0; i < n; i++) begin
                raw[8*i +: 8] = modelMem[base + i];
            end
            if (!code[2] && n < 8 && raw[8*n-1]) begin
                raw = raw | (~64'd0 << (8 * n));  // sign fill
            end
            r.data = raw;
        end
        return r;
    endfunction

    function automatic void applyStore(logic [2:0] code, logic [63:0] addr, logic [63:0] wdata);
        int base;
        base = int'(addr % modelBytes);
        if (!crossesLane(code, addr)) begin
            for (int i = 0; i < byteCount(code); i++) begin
                modelMem[base + i] = wdata[8*i +: 8];
            end
        end
    endfunction

    task automatic checkLoad(lsuBusPkg::loadRespT got, lsuBusPkg::loadRespT exp,
                             logic [63:0] addr);
        if (got.fault !== exp.fault || got.data !== exp.data) begin
            loadErrors++;
            $display("Mismatch at %0t: load addr %h gave fault %b data %h, expected %b %h",
                     $time, addr, got.fault, got.data, exp.fault, exp.data);
        end
    endtask

    task automatic checkFault(logic got, logic exp);
        if (got !== exp) begin
            faultErrors++;
            $display("Mismatch at %0t: storeFault is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic printCounts();
        $display("Errors: %0d load, %0d store fault, %0d other",
                 loadErrors, faultErrors, otherErrors);
    endtask

    // one request per falling edge, last cycle's storeFault checked first
    task automatic driveCycle(logic ren, logic wen, logic [2:0] code,
                              logic [63:0] addr, logic [63:0] wdata);
        @(negedge clk);
        checkFault(storeFault, expFaultNext);
        req.ren   = ren;
        req.wen   = wen;
        req.op    = memOpPkg::memOpE'(code);
        req.addr  = addr;
        req.wdata = wdata;
        if (ren) begin
            expQ.push_back(expectedLoad(code, addr));
            addrQ.push_back(addr);
        end
        expFaultNext = wen && crossesLane(code, addr);
        if (wen) begin
            applyStore(code, addr, wdata);
        end
    endtask

    initial begin : compareResponses
        int   waited;
        logic abort;
        waited = 0;
        @(negedge clk);
        while (rstN !== 1'b1 && waited < respTimeout) begin
            @(negedge clk);
            waited++;
        end
        abort = (rstN !== 1'b1);
        while (!abort) begin
            @(negedge clk);
            if (expQ.size() == 0) begin
                if (resp.valid !== 1'b0) begin
                    otherErrors++;
                    $display("Load response at %0t with no load outstanding", $time);
                end
            end else begin
                waited = 0;
                while (resp.valid !== 1'b1 && waited < respTimeout) begin
                    @(negedge clk);
                    waited++;
                end
                if (resp.valid !== 1'b1) begin
                    abort = 1'b1;
                end else begin
                    checkLoad(resp, expQ.pop_front(), addrQ.pop_front());
                end
            end
        end
        otherErrors++;
        $display("Timeout: no load response or reset release within %0d cycles", respTimeout);
        printCounts();
        $display("Simulation failed");
        $finish;
    end

    initial begin : runTests
        int          w;
        int          off;
        int          code;
        int          n;
        int          waited;
        logic [63:0] data;
        logic [63:0] addr;
        seed         = 32'h0a5af2be;
        clk          = 1'b0;
        rstN         = 1'b0;
        req          = '0;
        expFaultNext = 1'b0;
        loadErrors   = 0;
        faultErrors  = 0;
        otherErrors  = 0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;

        repeat (10) driveCycle(1'b0, 1'b0, 3'b000, 64'd0, 64'd0);  // quiet after reset

        for (w = 0; w < memDepth; w++) begin
            driveCycle(1'b0, 1'b1, 3'b011, 64'(w * 8), randWord());
            driveCycle(1'b1, 1'b0, 3'b011, 64'(w * 8), 64'd0);
        end

        // narrow stores, natural alignment, whole word and neighbour read back
        for (int k = 0; k < 48; k++) begin
            code = {$random(seed)} % 3;
            n    = byteCount(code[2:0]);
            w    = {$random(seed)} % memDepth;
            off  = ({$random(seed)} % 8) & ~(n - 1);
            driveCycle(1'b0, 1'b1, code[2:0], 64'(w * 8 + off), randWord());
            driveCycle(1'b1, 1'b0, 3'b011, 64'(w * 8), 64'd0);
            driveCycle(1'b1, 1'b0, 3'b011, 64'(((w + 1) % memDepth) * 8), 64'd0);
        end

        driveCycle(1'b1, 1'b1, 3'b011, 64'h28, randWord());  // same cycle, old data
        driveCycle(1'b1, 1'b0, 3'b011, 64'h28, 64'd0);

        // every code at every lane offset
        for (int p = 0; p < 3; p++) begin
            case (p)
                0:       data = 64'h8899aabbccddeeff;
                1:       data = 64'h7f017e027d037c04;
                default: data = 64'h80ff7f0180017ffe;
            endcase
            driveCycle(1'b0, 1'b1, 3'b011, 64'h48, data);
            for (code = 0; code < 8; code++) begin
                for (off = 0; off < 8; off++) begin
                    driveCycle(1'b1, 1'b0, code[2:0], 64'(72 + off), 64'd0);
                end
            end
        end

        // crossing loads and stores
        for (int k = 0; k < 18; k++) begin
            code = (k % 3 == 0) ? 0 : ((k % 3 == 1) ? 2 : 3);
            n    = byteCount(code[2:0]);
            w    = {$random(seed)} % memDepth;
            off  = (n == 2) ? 7 : 9 - n + ({$random(seed)} % (n - 1));
            addr = 64'(w * 8 + off);
            driveCycle(1'b1, 1'b0, code[2:0], addr, 64'd0);
            driveCycle(1'b0, 1'b1, code[2:0], addr, randWord());
            driveCycle(1'b1, 1'b0, 3'b011, 64'(w * 8), 64'd0);
        end

        // high address bits ignored
        for (int k = 0; k < 8; k++) begin
            w    = {$random(seed)} % memDepth;
            addr = (randWord() & ~64'h1ff) | 64'(w * 8);
            driveCycle(1'b0, 1'b1, 3'b011, addr, randWord());
            driveCycle(1'b1, 1'b0, 3'b011, 64'(w * 8), 64'd0);
            driveCycle(1'b1, 1'b0, 3'b001, addr + 64'd3, 64'd0);
            driveCycle(1'b1, 1'b0, 3'b011, 64'(modelBytes + w * 8), 64'd0);
        end

        repeat (4) driveCycle(1'b0, 1'b0, 3'b000, 64'd0, 64'd0);
        waited = 0;
        while (expQ.size() != 0 && waited < respTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            otherErrors++;
            $display("Load responses still outstanding at the end of the run");
        end

        printCounts();
        if (loadErrors + faultErrors + otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
